//--- source/rvIsaPkg.sv
package rvIsaPkg;

  // major opcodes in bits [6:0] of the instruction.
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111
  } opcodeT;

  // branch conditions.
  localparam logic [2:0] BEQ  = 3'b000;
  localparam logic [2:0] BNE  = 3'b001;
  localparam logic [2:0] BLT  = 3'b100;
  localparam logic [2:0] BGE  = 3'b101;
  localparam logic [2:0] BLTU = 3'b110;
  localparam logic [2:0] BGEU = 3'b111;

  // load widths.
  // stores use the same low two bits for SB, SH and SW.
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;

endpackage

//--- source/execCtrlPkg.sv
package execCtrlPkg;

  // ALU operations. PASSB forwards operand B (LUI).
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    SLL   = 4'd2,
    SLT   = 4'd3,
    SLTU  = 4'd4,
    XOR   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    OR    = 4'd8,
    AND   = 4'd9,
    PASSB = 4'd10
  } aluOpT;

  // the access size of loads and stores equals funct3[1:0].
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } loadSizeT;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import rvIsaPkg::*, execCtrlPkg::*; (
  input  logic [31:0] instr,
  input  logic        instrValid,
  output logic [4:0]  rs1Index,
  output logic [4:0]  rs2Index,
  output logic [4:0]  rdIndex,
  output logic [31:0] imm,
  output logic [2:0]  funct3,
  output aluOpT       aluOp,
  output logic        aluSrc,
  output logic        pcToAlu,
  output logic        memRead,
  output logic        memWrite,
  output loadSizeT    memSize,
  output logic        unsignedLoad,
  output logic        regWrite,
  output logic        branch,
  output logic        jump,
  output logic        jumpRegister,
  output logic        decValid
);

  opcodeT      opcode;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immU;
  logic [31:0] immJ;
  logic        writesRd;

  function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt,
                                         input logic regForm);
    aluOpT op;
    case (f3)
      3'b000:  op = (regForm && alt) ? SUB : ADD; // no SUBI.
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  function automatic loadSizeT sizeOf(input logic [2:0] f3);
    loadSizeT size;
    case (f3)
      LB, LBU: size = BYTE;
      LH, LHU: size = HALF;
      LW:      size = WORD;
      default: size = WORD;
    endcase
    return size;
  endfunction

  assign opcode   = opcodeT'(instr[6:0]);
  assign rs1Index = instr[19:15];
  assign rs2Index = instr[24:20];
  assign rdIndex  = instr[11:7];
  assign funct3   = instr[14:12];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'd0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm          = 32'd0;
    aluOp        = ADD;
    aluSrc       = 1'b0;
    pcToAlu      = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    memSize      = BYTE;
    unsignedLoad = 1'b0;
    writesRd     = 1'b0;
    branch       = 1'b0;
    jump         = 1'b0;
    jumpRegister = 1'b0;
    decValid     = 1'b0;
    if (instrValid) begin
      decValid = 1'b1;
      case (opcode)
        OP: begin
          aluOp    = aluFromFunct(funct3, instr[30], 1'b1);
          writesRd = 1'b1;
        end
        OP_IMM: begin
          imm      = immI;
          aluOp    = aluFromFunct(funct3, instr[30], 1'b0);
          aluSrc   = 1'b1;
          writesRd = 1'b1;
        end
        LOAD: begin
          imm          = immI;
          aluSrc       = 1'b1;
          memRead      = 1'b1;
          memSize      = sizeOf(funct3);
          unsignedLoad = funct3[2];
          writesRd     = 1'b1;
        end
        STORE: begin
          imm      = immS;
          aluSrc   = 1'b1;
          memWrite = 1'b1;
          memSize  = sizeOf(funct3);
        end
        BRANCH: begin
          imm    = immB;
          branch = 1'b1;
        end
        LUI: begin
          imm      = immU;
          aluOp    = PASSB;
          aluSrc   = 1'b1;
          writesRd = 1'b1;
        end
        AUIPC: begin
          imm      = immU;
          aluSrc   = 1'b1;
          pcToAlu  = 1'b1;
          writesRd = 1'b1;
        end
        JAL: begin
          imm      = immJ;
          jump     = 1'b1;
          writesRd = 1'b1;
        end
        JALR: begin
          imm          = immI;
          jump         = 1'b1;
          jumpRegister = 1'b1;
          writesRd     = 1'b1;
        end
        default: decValid = 1'b0; // fence, system and unknown become bubbles.
      endcase
    end
  end

  assign regWrite = writesRd && (rdIndex != 5'd0);

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
  parameter int regCount = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1Index,
  input  logic [4:0]  rs2Index,
  output logic [31:0] rs1Value,
  output logic [31:0] rs2Value,
  input  logic        wbWrite,
  input  logic [4:0]  wbIndex,
  input  logic [31:0] wbData
);

  logic [31:0] regs [regCount];

  // x0 and indices beyond regCount read as zero.
  function automatic logic [31:0] readPort(input logic [4:0] index);
    logic [31:0] value;
    if (index == 5'd0 || index >= regCount)
      value = 32'd0;
    else if (wbWrite && wbIndex == index)
      value = wbData; // write-through.
    else
      value = regs[index];
    return value;
  endfunction

  always_comb begin
    rs1Value = readPort(rs1Index);
    rs2Value = readPort(rs2Index);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wbWrite && wbIndex != 5'd0 && wbIndex < regCount) begin
      regs[wbIndex] <= wbData;
    end
  end

endmodule

//--- source/idExBarrier.sv
`timescale 1ns/1ps

module idExBarrier import execCtrlPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        stall,
  input  logic        flush,
  input  logic [31:0] idPc,
  input  logic [31:0] idRs1Value,
  input  logic [31:0] idRs2Value,
  input  logic [31:0] idImm,
  input  logic [2:0]  idFunct3,
  input  aluOpT       idAluOp,
  input  logic        idAluSrc,
  input  logic        idPcToAlu,
  input  logic        idMemRead,
  input  logic        idMemWrite,
  input  loadSizeT    idMemSize,
  input  logic        idUnsignedLoad,
  input  logic        idRegWrite,
  input  logic [4:0]  idRdIndex,
  input  logic        idBranch,
  input  logic        idJump,
  input  logic        idJumpRegister,
  input  logic        idValid,
  output logic [31:0] exPc,
  output logic [31:0] exRs1Value,
  output logic [31:0] exRs2Value,
  output logic [31:0] exImm,
  output logic [2:0]  exFunct3,
  output aluOpT       exAluOp,
  output logic        exAluSrc,
  output logic        exPcToAlu,
  output logic        exMemRead,
  output logic        exMemWrite,
  output loadSizeT    exMemSize,
  output logic        exUnsignedLoad,
  output logic        exRegWrite,
  output logic [4:0]  exRdIndex,
  output logic        exBranch,
  output logic        exJump,
  output logic        exJumpRegister,
  output logic        exValid
);

  // payload holds under stall.
  always_ff @(posedge clk) begin
    if (!stall) begin
      exPc       <= idPc;
      exRs1Value <= idRs1Value;
      exRs2Value <= idRs2Value;
      exImm      <= idImm;
      exFunct3   <= idFunct3;
      exRdIndex  <= idRdIndex;
    end
  end

  // a flush turns the captured instruction into a bubble.
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      exAluOp        <= ADD;
      exAluSrc       <= 1'b0;
      exPcToAlu      <= 1'b0;
      exMemRead      <= 1'b0;
      exMemWrite     <= 1'b0;
      exMemSize      <= BYTE;
      exUnsignedLoad <= 1'b0;
      exRegWrite     <= 1'b0;
      exBranch       <= 1'b0;
      exJump         <= 1'b0;
      exJumpRegister <= 1'b0;
      exValid        <= 1'b0;
    end else if (!stall) begin
      exAluOp        <= idAluOp;
      exAluSrc       <= idAluSrc;
      exPcToAlu      <= idPcToAlu;
      exMemRead      <= idMemRead;
      exMemWrite     <= idMemWrite;
      exMemSize      <= idMemSize;
      exUnsignedLoad <= idUnsignedLoad;
      exRegWrite     <= idRegWrite;
      exBranch       <= idBranch;
      exJump         <= idJump;
      exJumpRegister <= idJumpRegister;
      exValid        <= idValid;
    end
  end

endmodule

//--- source/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import rvIsaPkg::*, execCtrlPkg::*; (
  input  logic [31:0] exPc,
  input  logic [31:0] exRs1Value,
  input  logic [31:0] exRs2Value,
  input  logic [31:0] exImm,
  input  logic [2:0]  exFunct3,
  input  aluOpT       exAluOp,
  input  logic        exAluSrc,
  input  logic        exPcToAlu,
  input  logic        exMemWrite,
  input  loadSizeT    exMemSize,
  input  logic        exBranch,
  input  logic        exJump,
  input  logic        exJumpRegister,
  input  logic        exValid,
  output logic [31:0] aluResult,
  output logic        branchTaken,
  output logic [31:0] branchTarget,
  output logic [31:0] storeData
);

  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluOut;
  logic [31:0] jalrSum;
  logic [31:0] target;
  logic [31:0] aligned;
  logic        condMet;

  assign opA = exPcToAlu ? exPc : exRs1Value;
  assign opB = exAluSrc ? exImm : exRs2Value;

  always_comb begin
    case (exAluOp)
      ADD:     aluOut = opA + opB; // also load and store address.
      SUB:     aluOut = opA - opB;
      SLL:     aluOut = opA << opB[4:0];
      SLT:     aluOut = {31'd0, $signed(opA) < $signed(opB)};
      SLTU:    aluOut = {31'd0, opA < opB};
      XOR:     aluOut = opA ^ opB;
      SRL:     aluOut = opA >> opB[4:0];
      SRA:     aluOut = $unsigned($signed(opA) >>> opB[4:0]);
      OR:      aluOut = opA | opB;
      AND:     aluOut = opA & opB;
      PASSB:   aluOut = opB;
      default: aluOut = 32'd0;
    endcase
  end

  always_comb begin
    case (exFunct3)
      BEQ:     condMet = exRs1Value == exRs2Value;
      BNE:     condMet = exRs1Value != exRs2Value;
      BLT:     condMet = $signed(exRs1Value) < $signed(exRs2Value);
      BGE:     condMet = $signed(exRs1Value) >= $signed(exRs2Value);
      BLTU:    condMet = exRs1Value < exRs2Value;
      BGEU:    condMet = exRs1Value >= exRs2Value;
      default: condMet = 1'b0;
    endcase
  end

  assign jalrSum = exRs1Value + exImm;
  assign target  = exJumpRegister ? {jalrSum[31:1], 1'b0} : exPc + exImm;

  // replicate the low lanes so every byte enable sees its data.
  always_comb begin
    case (exMemSize)
      BYTE:    aligned = {4{exRs2Value[7:0]}};
      HALF:    aligned = {2{exRs2Value[15:0]}};
      default: aligned = exRs2Value;
    endcase
  end

  assign aluResult    = !exValid ? 32'd0 : (exJump ? exPc + 32'd4 : aluOut); // link value.
  assign branchTaken  = exValid && (exJump || (exBranch && condMet));
  assign branchTarget = exValid ? target : 32'd0;
  assign storeData    = (exValid && exMemWrite) ? aligned : 32'd0;

endmodule

//--- source/decodeExecuteTop.sv
`timescale 1ns/1ps

module decodeExecuteTop import execCtrlPkg::*; #(
  parameter int regCount = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        stall,
  input  logic [31:0] instr,
  input  logic [31:0] pc,
  input  logic        instrValid,
  input  logic        wbWrite,
  input  logic [4:0]  wbIndex,
  input  logic [31:0] wbData,
  output logic        exValid,
  output logic [31:0] exAluResult,
  output logic        exRegWrite,
  output logic [4:0]  exWriteIndex,
  output logic        exMemRead,
  output logic        exMemWrite,
  output loadSizeT    exMemSize,
  output logic        exUnsignedLoad,
  output logic [31:0] exStoreData,
  output logic        exBranchTaken,
  output logic [31:0] exBranchTarget
);

  logic [4:0]  rs1Index;
  logic [4:0]  rs2Index;
  logic [4:0]  idRdIndex;
  logic [31:0] idImm;
  logic [2:0]  idFunct3;
  aluOpT       idAluOp;
  logic        idAluSrc;
  logic        idPcToAlu;
  logic        idMemRead;
  logic        idMemWrite;
  loadSizeT    idMemSize;
  logic        idUnsignedLoad;
  logic        idRegWrite;
  logic        idBranch;
  logic        idJump;
  logic        idJumpRegister;
  logic        idValid;
  logic [31:0] idRs1Value;
  logic [31:0] idRs2Value;

  logic [31:0] exPc;
  logic [31:0] exRs1Value;
  logic [31:0] exRs2Value;
  logic [31:0] exImm;
  logic [2:0]  exFunct3;
  aluOpT       exAluOp;
  logic        exAluSrc;
  logic        exPcToAlu;
  logic        exBranch;
  logic        exJump;
  logic        exJumpRegister;

  instrDecoder instrDecoder_i (
    .instr, .instrValid, .rs1Index, .rs2Index,
    .rdIndex(idRdIndex), .imm(idImm), .funct3(idFunct3), .aluOp(idAluOp),
    .aluSrc(idAluSrc), .pcToAlu(idPcToAlu), .memRead(idMemRead), .memWrite(idMemWrite),
    .memSize(idMemSize), .unsignedLoad(idUnsignedLoad), .regWrite(idRegWrite),
    .branch(idBranch), .jump(idJump), .jumpRegister(idJumpRegister), .decValid(idValid)
  );

  registerFile #(.regCount(regCount)) registerFile_i (
    .clk, .rst, .rs1Index, .rs2Index,
    .rs1Value(idRs1Value), .rs2Value(idRs2Value),
    .wbWrite, .wbIndex, .wbData
  );

  // a taken branch or jump in execute kills the instruction behind it.
  idExBarrier idExBarrier_i (
    .clk, .rst, .stall, .flush(exBranchTaken),
    .idPc(pc), .idRs1Value, .idRs2Value, .idImm, .idFunct3, .idAluOp, .idAluSrc,
    .idPcToAlu, .idMemRead, .idMemWrite, .idMemSize, .idUnsignedLoad, .idRegWrite,
    .idRdIndex, .idBranch, .idJump, .idJumpRegister, .idValid,
    .exPc, .exRs1Value, .exRs2Value, .exImm, .exFunct3, .exAluOp, .exAluSrc,
    .exPcToAlu, .exMemRead, .exMemWrite, .exMemSize, .exUnsignedLoad, .exRegWrite,
    .exRdIndex(exWriteIndex), .exBranch, .exJump, .exJumpRegister, .exValid
  );

  executeUnit executeUnit_i (
    .exPc, .exRs1Value, .exRs2Value, .exImm, .exFunct3, .exAluOp, .exAluSrc,
    .exPcToAlu, .exMemWrite, .exMemSize, .exBranch, .exJump, .exJumpRegister, .exValid,
    .aluResult(exAluResult), .branchTaken(exBranchTaken),
    .branchTarget(exBranchTarget), .storeData(exStoreData)
  );

endmodule

//--- sim/decodeExecuteTb.sv
`timescale 1ns/1ps

module decodeExecuteTb import rvIsaPkg::*, execCtrlPkg::*; ();

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        valid;
    logic        stall;
    logic [4:0]  wbIdx;
    logic [31:0] wbVal;
  } rowT;

  typedef struct packed {
    logic        valid;
    logic [31:0] result;
    logic        useResult;
    logic        regWrite;
    logic [4:0]  rd;
    logic        memRead;
    logic        memWrite;
    logic [1:0]  size;
    logic        unsignedLoad;
    logic [31:0] storeData;
    logic        taken;
    logic [31:0] target;
    logic        useTarget;
  } expectT;

  localparam int setupCycles = 8 + 31 + 1; // reset, register fill, last check.

  logic        clk;
  logic        rst;
  logic        stall;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        instrValid;
  logic        wbWrite;
  logic [4:0]  wbIndex;
  logic [31:0] wbData;
  logic        exValid;
  logic [31:0] exAluResult;
  logic        exRegWrite;
  logic [4:0]  exWriteIndex;
  logic        exMemRead;
  logic        exMemWrite;
  loadSizeT    exMemSize;
  logic        exUnsignedLoad;
  logic [31:0] exStoreData;
  logic        exBranchTaken;
  logic [31:0] exBranchTarget;

  rowT         rows[$];
  logic [31:0] regCopy [32];
  logic [31:0] nextPc;
  expectT      held; // what the barrier holds right now.
  int          seed = 32'h7536_d83a;
  int          errors = 0;
  int          cycles = 0;
  int          cycleLimit = 1000;

  decodeExecuteTop #(.regCount(32)) decodeExecuteTop_i (
    .clk, .rst, .stall, .instr, .pc, .instrValid, .wbWrite, .wbIndex, .wbData,
    .exValid, .exAluResult, .exRegWrite, .exWriteIndex, .exMemRead, .exMemWrite,
    .exMemSize, .exUnsignedLoad, .exStoreData, .exBranchTaken, .exBranchTarget
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Summary: %0d errors", errors);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcodeT op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                        input opcodeT op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  function automatic expectT bubble();
    expectT e;
    e = '0;
    e.useResult = 1'b1; // gated outputs read zero.
    e.useTarget = 1'b1;
    return e;
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branchHolds(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // reference model of one instruction sitting in execute.
  function automatic expectT predict(input logic [31:0] ins, input logic [31:0] pcIn);
    expectT      e;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        writes;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    e = bubble();
    a = regCopy[ins[19:15]];
    b = regCopy[ins[24:20]];
    f3 = ins[14:12];
    writes = 1'b1;
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immU = {ins[31:12], 12'h000};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e.valid = 1'b1;
    e.rd = ins[11:7];
    e.useTarget = 1'b0;
    case (ins[6:0])
      OP:     e.result = aluRef(f3, ins[30], a, b);
      OP_IMM: e.result = aluRef(f3, ins[30] && f3 == 3'b101, a, immI);
      LOAD: begin
        e.result = a + immI;
        e.memRead = 1'b1;
        e.size = f3[1:0];
        e.unsignedLoad = f3[2];
      end
      STORE: begin
        writes = 1'b0;
        e.result = a + immS;
        e.memWrite = 1'b1;
        e.size = f3[1:0];
        e.storeData = (f3[1:0] == 2'b00) ? {4{b[7:0]}} : (f3[1:0] == 2'b01) ? {2{b[15:0]}} : b;
      end
      BRANCH: begin
        writes = 1'b0;
        e.useResult = 1'b0;
        e.useTarget = 1'b1;
        e.target = pcIn + immB;
        e.taken = branchHolds(f3, a, b);
      end
      LUI:   e.result = immU;
      AUIPC: e.result = pcIn + immU;
      JAL, JALR: begin
        e.result = pcIn + 32'd4;
        e.taken = 1'b1;
        e.useTarget = 1'b1;
        e.target = (ins[6:0] == JAL) ? pcIn + immJ : (a + immI) & ~32'd1;
      end
      default: begin
        writes = 1'b0;
        e = bubble(); // fence, system and the rest.
      end
    endcase
    e.regWrite = writes && e.rd != 5'd0;
    return e;
  endfunction

  task automatic pushRow(input logic [31:0] ins, input logic valid, input logic hold,
                         input logic [4:0] wbIdx, input logic [31:0] wbVal);
    rowT r;
    r.instr = ins;
    r.pc = nextPc;
    r.valid = valid;
    r.stall = hold;
    r.wbIdx = wbIdx;
    r.wbVal = wbVal;
    rows.push_back(r);
    nextPc = nextPc + 32'd4;
  endtask

  task automatic pushInstr(input logic [31:0] ins);
    pushRow(ins, 1'b1, 1'b0, 5'd0, 32'd0);
  endtask

  // the filler behind a branch or jump is flushed when it is taken.
  task automatic pushWithFiller(input logic [31:0] ins);
    pushInstr(ins);
    pushInstr(iType(12'd1, 5'd2, 3'b000, 5'd2, OP_IMM));
  endtask

  task automatic buildTable();
    nextPc = 32'h0000_1000;
    pushRow(rType(7'h00, 5'd3, 5'd7, 3'b000, 5'd9), 1'b1, 1'b0, 5'd7, 32'hffff_fff0);
    pushRow(rType(7'h20, 5'd7, 5'd8, 3'b000, 5'd10), 1'b1, 1'b0, 5'd8, 32'd5);
    pushInstr(rType(7'h00, 5'd2, 5'd1, 3'b001, 5'd11));
    pushInstr(rType(7'h00, 5'd8, 5'd7, 3'b010, 5'd12));
    pushInstr(rType(7'h00, 5'd8, 5'd7, 3'b011, 5'd13));
    pushInstr(rType(7'h00, 5'd5, 5'd4, 3'b100, 5'd14));
    pushInstr(rType(7'h00, 5'd8, 5'd7, 3'b101, 5'd15));
    pushInstr(rType(7'h20, 5'd8, 5'd7, 3'b101, 5'd16));
    pushInstr(rType(7'h00, 5'd6, 5'd1, 3'b110, 5'd17));
    pushInstr(rType(7'h00, 5'd6, 5'd2, 3'b111, 5'd18));
    pushInstr(iType(12'hff9, 5'd3, 3'b000, 5'd19, OP_IMM));
    pushInstr(iType(12'd3, 5'd7, 3'b010, 5'd20, OP_IMM));
    pushInstr(iType(12'd9, 5'd8, 3'b011, 5'd21, OP_IMM));
    pushInstr(iType(12'h5a5, 5'd4, 3'b100, 5'd22, OP_IMM));
    pushInstr(iType(12'h0f0, 5'd5, 3'b110, 5'd23, OP_IMM));
    pushInstr(iType(12'h7ff, 5'd6, 3'b111, 5'd24, OP_IMM));
    pushInstr(iType(12'd13, 5'd1, 3'b001, 5'd25, OP_IMM));
    pushInstr(iType(12'd4, 5'd7, 3'b101, 5'd26, OP_IMM));
    pushInstr(iType(12'h404, 5'd7, 3'b101, 5'd27, OP_IMM));
    pushInstr(uType(20'habcde, 5'd28, LUI));
    pushInstr(uType(20'h12345, 5'd29, AUIPC));
    pushInstr(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd0)); // rd zero.
    pushInstr(iType(12'hffc, 5'd8, LB, 5'd30, LOAD));
    pushInstr(iType(12'd2, 5'd9, LH, 5'd31, LOAD));
    pushInstr(iType(12'h100, 5'd1, LW, 5'd4, LOAD));
    pushInstr(iType(12'h7ff, 5'd2, LBU, 5'd5, LOAD));
    pushInstr(iType(12'h800, 5'd3, LHU, 5'd6, LOAD));
    pushInstr(sType(12'd3, 5'd7, 5'd8, 3'b000));
    pushInstr(sType(12'hffe, 5'd7, 5'd9, 3'b001));
    pushInstr(sType(12'd16, 5'd6, 5'd1, 3'b010));
    // x7 is negative and x8 is 5, so each pair below is taken then not taken.
    pushWithFiller(bType(13'h040, 5'd7, 5'd7, BEQ));
    pushWithFiller(bType(13'h1f80, 5'd7, 5'd8, BEQ));
    pushWithFiller(bType(13'h0c8, 5'd7, 5'd8, BNE));
    pushWithFiller(bType(13'h010, 5'd8, 5'd8, BNE));
    pushWithFiller(bType(13'h1ffc, 5'd7, 5'd8, BLT));
    pushWithFiller(bType(13'h020, 5'd8, 5'd7, BLT));
    pushWithFiller(bType(13'h800, 5'd8, 5'd7, BGE));
    pushWithFiller(bType(13'h044, 5'd7, 5'd8, BGE));
    pushWithFiller(bType(13'h1e00, 5'd8, 5'd7, BLTU));
    pushWithFiller(bType(13'h008, 5'd7, 5'd8, BLTU));
    pushWithFiller(bType(13'h0fe, 5'd7, 5'd8, BGEU));
    pushWithFiller(bType(13'h00c, 5'd8, 5'd7, BGEU));
    pushWithFiller(jType(21'h100, 5'd1));
    pushWithFiller(iType(12'd6, 5'd8, 3'b000, 5'd5, JALR));
    pushInstr(iType(12'h123, 5'd0, 3'b000, 5'd3, OP_IMM));
    pushRow(rType(7'h00, 5'd5, 5'd4, 3'b100, 5'd6), 1'b1, 1'b1, 5'd0, 32'd0);
    pushRow(iType(12'd8, 5'd1, LW, 5'd7, LOAD), 1'b1, 1'b1, 5'd0, 32'd0);
    pushRow(jType(21'h040, 5'd1), 1'b1, 1'b1, 5'd0, 32'd0);
    pushInstr(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
    pushRow(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0, 1'b0, 5'd0, 32'd0);
    pushInstr(32'h0000_000f);
    pushInstr(32'h0000_0073);
    pushInstr(rType(7'h20, 5'd1, 5'd2, 3'b000, 5'd12));
  endtask

  task automatic checkValue(input int row, input string name, input logic [31:0] got,
                            input logic [31:0] want);
    assert (got === want) else begin
      $display("Error: row %0d %s is %h, expected %h", row, name, got, want);
      errors++;
    end
  endtask

  task automatic compare(input int row, input expectT e);
    checkValue(row, "exValid", 32'(exValid), 32'(e.valid));
    checkValue(row, "exRegWrite", 32'(exRegWrite), 32'(e.regWrite));
    checkValue(row, "exMemRead", 32'(exMemRead), 32'(e.memRead));
    checkValue(row, "exMemWrite", 32'(exMemWrite), 32'(e.memWrite));
    checkValue(row, "exBranchTaken", 32'(exBranchTaken), 32'(e.taken));
    checkValue(row, "exStoreData", exStoreData, e.storeData);
    if (e.useResult)
      checkValue(row, "exAluResult", exAluResult, e.result);
    if (e.useTarget)
      checkValue(row, "exBranchTarget", exBranchTarget, e.target);
    if (e.valid)
      checkValue(row, "exWriteIndex", 32'(exWriteIndex), 32'(e.rd));
    if (e.memRead || e.memWrite) begin
      checkValue(row, "exMemSize", 32'(exMemSize), 32'(e.size));
      checkValue(row, "exUnsignedLoad", 32'(exUnsignedLoad), 32'(e.unsignedLoad));
    end
  endtask

  task automatic applyRow(input rowT r);
    instr = r.instr;
    pc = r.pc;
    instrValid = r.valid;
    stall = r.stall;
    wbWrite = r.wbIdx != 5'd0;
    wbIndex = r.wbIdx;
    wbData = r.wbVal;
    if (r.wbIdx != 5'd0)
      regCopy[r.wbIdx] = r.wbVal; // write-through reaches this row's reads.
    if (held.taken)
      held = bubble(); // flush wins over stall.
    else if (!r.stall)
      held = r.valid ? predict(r.instr, r.pc) : bubble();
  endtask

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    instr = 32'd0;
    pc = 32'd0;
    instrValid = 1'b0;
    wbWrite = 1'b0;
    wbIndex = 5'd0;
    wbData = 32'd0;
    buildTable();
    cycleLimit = rows.size() + setupCycles + 20;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    compare(0, bubble());
    regCopy[0] = 32'd0;
    for (int i = 1; i < 32; i++) begin
      @(posedge clk);
      #1;
      wbWrite = 1'b1;
      wbIndex = 5'(i);
      wbData = $random(seed);
      regCopy[i] = wbData;
    end
    held = bubble();
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0)
        compare(i, held);
      applyRow(rows[i]);
    end
    @(posedge clk);
    #1;
    compare(rows.size(), held);
    $display("Summary: %0d errors", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- verilog.f
source/rvIsaPkg.sv
source/execCtrlPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/idExBarrier.sv
source/executeUnit.sv
source/decodeExecuteTop.sv
sim/decodeExecuteTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, then checks the log.
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module decodeExecuteTb -f verilog.f -o simv \
  && ./obj_dir/simv | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
